/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    ////////////////////
    // widths

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t INST_ADDR_STEP = 4; // return address offset

    ////////////////////
    // opcodes and funct fields

    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I_ALU  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub / sra

    ////////////////////
    // control and data types

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        WB_ALU, WB_LOAD, WB_IMM_U, WB_PC_IMM_U, WB_PC_LINK, WB_NONE
    } wb_sel_e;

    // nine conditions, so four bits
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_cond_e;

    typedef enum logic [2:0] {
        LD_B, LD_H, LD_W, LD_BU, LD_HU
    } ld_kind_e;

    typedef struct packed {
        alu_op_e  alu_op;
        wb_sel_e  wb_sel;
        br_cond_e br_cond;
        ld_kind_e ld_kind;
        logic     reg_wr_en;
        word_t    imm_u;
        word_t    jump_offset; // imm_j for jal, offset for branches
    } ex_ctrl_t;

    typedef struct packed {
        word_t     inst;
        word_t     pc;
        word_t     op1;
        word_t     op2;
        reg_addr_t rd_addr;
        word_t     offset;
    } ex_in_t;

    typedef struct packed {
        logic      reg_wr_en;
        reg_addr_t rd_addr;
        word_t     rd_data;
        logic      jump_en;
        word_t     jump_addr;
    } ex_out_t;

endpackage

`default_nettype wire

/* rtl/inst_decoder.sv */
`default_nettype none

module inst_decoder (
    input  rv_pkg::word_t    inst_i,
    input  rv_pkg::word_t    offset_i,
    output rv_pkg::ex_ctrl_t ctrl_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_r;
    logic            f7_base;
    logic            f7_alt;
    logic            alu_ok;
    rv_pkg::alu_op_e alu_op;
    rv_pkg::word_t   imm_j;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign is_r    = (opcode == rv_pkg::OPC_R);
    assign f7_base = (funct7 == rv_pkg::FUNCT7_BASE);
    assign f7_alt  = (funct7 == rv_pkg::FUNCT7_ALT);
    assign imm_j   = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    ////////////////////
    // alu op, shared by r and i forms

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        alu_ok = f7_base || !is_r; // i forms carry imm bits here
        case (funct3)
            rv_pkg::F3_ADD_SUB: begin
                if (is_r && f7_alt) begin
                    alu_op = rv_pkg::ALU_SUB;
                    alu_ok = 1'b1;
                end
            end
            rv_pkg::F3_SLL: begin
                alu_op = rv_pkg::ALU_SLL;
                alu_ok = f7_base;
            end
            rv_pkg::F3_SLT:  alu_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:  alu_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_OR:   alu_op = rv_pkg::ALU_OR;
            rv_pkg::F3_AND:  alu_op = rv_pkg::ALU_AND;
            rv_pkg::F3_SRL_SRA: begin
                alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                alu_ok = f7_base || f7_alt;
            end
            default: alu_ok = 1'b0;
        endcase
    end

    ////////////////////
    // main decode

    always_comb begin
        ctrl_o.alu_op      = rv_pkg::ALU_ADD; // address add for loads, jalr
        ctrl_o.wb_sel      = rv_pkg::WB_NONE;
        ctrl_o.br_cond     = rv_pkg::BR_NONE;
        ctrl_o.ld_kind     = rv_pkg::LD_W;
        ctrl_o.reg_wr_en   = 1'b0;
        ctrl_o.imm_u       = {inst_i[31:12], 12'b0};
        ctrl_o.jump_offset = offset_i;
        case (opcode)
            rv_pkg::OPC_R, rv_pkg::OPC_I_ALU: begin
                if (alu_ok) begin
                    ctrl_o.alu_op    = alu_op;
                    ctrl_o.wb_sel    = rv_pkg::WB_ALU;
                    ctrl_o.reg_wr_en = 1'b1;
                end
            end
            rv_pkg::OPC_LOAD: begin
                ctrl_o.wb_sel    = rv_pkg::WB_LOAD;
                ctrl_o.reg_wr_en = 1'b1;
                case (funct3)
                    rv_pkg::F3_LB:  ctrl_o.ld_kind = rv_pkg::LD_B;
                    rv_pkg::F3_LH:  ctrl_o.ld_kind = rv_pkg::LD_H;
                    rv_pkg::F3_LW:  ctrl_o.ld_kind = rv_pkg::LD_W;
                    rv_pkg::F3_LBU: ctrl_o.ld_kind = rv_pkg::LD_BU;
                    rv_pkg::F3_LHU: ctrl_o.ld_kind = rv_pkg::LD_HU;
                    default: begin
                        ctrl_o.wb_sel    = rv_pkg::WB_NONE;
                        ctrl_o.reg_wr_en = 1'b0;
                    end
                endcase
            end
            rv_pkg::OPC_STORE: ; // no write-back from this stage
            rv_pkg::OPC_BRANCH: begin
                case (funct3)
                    rv_pkg::F3_BEQ:  ctrl_o.br_cond = rv_pkg::BR_EQ;
                    rv_pkg::F3_BNE:  ctrl_o.br_cond = rv_pkg::BR_NE;
                    rv_pkg::F3_BLT:  ctrl_o.br_cond = rv_pkg::BR_LT;
                    rv_pkg::F3_BGE:  ctrl_o.br_cond = rv_pkg::BR_GE;
                    rv_pkg::F3_BLTU: ctrl_o.br_cond = rv_pkg::BR_LTU;
                    rv_pkg::F3_BGEU: ctrl_o.br_cond = rv_pkg::BR_GEU;
                    default:         ctrl_o.br_cond = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.wb_sel    = rv_pkg::WB_IMM_U;
                ctrl_o.reg_wr_en = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl_o.wb_sel    = rv_pkg::WB_PC_IMM_U;
                ctrl_o.reg_wr_en = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.wb_sel      = rv_pkg::WB_PC_LINK;
                ctrl_o.br_cond     = rv_pkg::BR_JAL;
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.jump_offset = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                if (funct3 == rv_pkg::F3_JALR) begin
                    ctrl_o.wb_sel    = rv_pkg::WB_PC_LINK;
                    ctrl_o.br_cond   = rv_pkg::BR_JALR;
                    ctrl_o.reg_wr_en = 1'b1;
                end
            end
            default: ; // system and unknown opcodes
        endcase
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu (
    input  rv_pkg::alu_op_e alu_op_i,
    input  rv_pkg::word_t   op1_i,
    input  rv_pkg::word_t   op2_i,
    output rv_pkg::word_t   res_o
);

    logic [4:0] shamt;
    logic       lt;
    logic       ltu;

    assign shamt = op2_i[4:0]; // low 5 bits only
    assign lt    = $signed(op1_i) < $signed(op2_i);
    assign ltu   = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:  res_o = op1_i + op2_i;
            rv_pkg::ALU_SUB:  res_o = op1_i - op2_i;
            rv_pkg::ALU_AND:  res_o = op1_i & op2_i;
            rv_pkg::ALU_OR:   res_o = op1_i | op2_i;
            rv_pkg::ALU_XOR:  res_o = op1_i ^ op2_i;
            rv_pkg::ALU_SLT:  res_o = {{(rv_pkg::XLEN-1){1'b0}}, lt};
            rv_pkg::ALU_SLTU: res_o = {{(rv_pkg::XLEN-1){1'b0}}, ltu};
            rv_pkg::ALU_SLL:  res_o = op1_i << shamt;
            rv_pkg::ALU_SRL:  res_o = op1_i >> shamt;
            rv_pkg::ALU_SRA:  res_o = $signed(op1_i) >>> shamt; // keeps sign
            default:          res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
`default_nettype none

module branch_unit (
    input  rv_pkg::br_cond_e br_cond_i,
    input  rv_pkg::word_t    pc_i,
    input  rv_pkg::word_t    op1_i,
    input  rv_pkg::word_t    op2_i,
    input  rv_pkg::word_t    jump_offset_i,
    input  rv_pkg::word_t    alu_res_i,
    output logic             jump_en_o,
    output rv_pkg::word_t    jump_addr_o
);

    logic          eq;
    logic          lt;
    logic          ltu;
    logic          taken;
    rv_pkg::word_t target;

    assign eq  = (op1_i == op2_i);
    assign lt  = $signed(op1_i) < $signed(op2_i);
    assign ltu = op1_i < op2_i;

    always_comb begin
        case (br_cond_i)
            rv_pkg::BR_EQ:   taken = eq;
            rv_pkg::BR_NE:   taken = !eq;
            rv_pkg::BR_LT:   taken = lt;
            rv_pkg::BR_GE:   taken = !lt;
            rv_pkg::BR_LTU:  taken = ltu;
            rv_pkg::BR_GEU:  taken = !ltu;
            rv_pkg::BR_JAL:  taken = 1'b1;
            rv_pkg::BR_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // jalr target is rs1 + imm with bit 0 dropped
    assign target = (br_cond_i == rv_pkg::BR_JALR) ?
                    {alu_res_i[rv_pkg::XLEN-1:1], 1'b0} :
                    pc_i + jump_offset_i;

    assign jump_en_o   = taken;
    assign jump_addr_o = taken ? target : '0; // zero when not jumping

endmodule

`default_nettype wire

/* rtl/load_align.sv */
`default_nettype none

module load_align (
    input  rv_pkg::ld_kind_e ld_kind_i,
    input  logic [1:0]       byte_off_i,
    input  rv_pkg::word_t    ram_data_i,
    output rv_pkg::word_t    load_data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    always_comb begin
        case (byte_off_i)
            2'd0:    byte_lane = ram_data_i[7:0];
            2'd1:    byte_lane = ram_data_i[15:8];
            2'd2:    byte_lane = ram_data_i[23:16];
            default: byte_lane = ram_data_i[31:24];
        endcase
    end

    assign half_lane = byte_off_i[1] ? ram_data_i[31:16] : ram_data_i[15:0]; // bit 0 ignored

    always_comb begin
        case (ld_kind_i)
            rv_pkg::LD_B:  load_data_o = {{(rv_pkg::XLEN-8){byte_lane[7]}}, byte_lane};
            rv_pkg::LD_H:  load_data_o = {{(rv_pkg::XLEN-16){half_lane[15]}}, half_lane};
            rv_pkg::LD_BU: load_data_o = {{(rv_pkg::XLEN-8){1'b0}}, byte_lane};
            rv_pkg::LD_HU: load_data_o = {{(rv_pkg::XLEN-16){1'b0}}, half_lane};
            rv_pkg::LD_W:  load_data_o = ram_data_i;
            default:       load_data_o = ram_data_i;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            valid_i,
    input  rv_pkg::ex_in_t  ex_i,
    input  rv_pkg::word_t   ram_rd_data_i,
    output rv_pkg::ex_out_t ex_o
);

    rv_pkg::ex_ctrl_t ctrl;
    rv_pkg::word_t    alu_res;
    rv_pkg::word_t    load_data;
    rv_pkg::word_t    jump_addr;
    rv_pkg::word_t    link_addr;
    rv_pkg::word_t    pc_imm_u;
    rv_pkg::word_t    rd_data;
    logic             jump_en;
    rv_pkg::ex_out_t  ex_next;

    inst_decoder u_dec (
        .inst_i  (ex_i.inst),
        .offset_i(ex_i.offset),
        .ctrl_o  (ctrl)
    );

    alu u_alu (
        .alu_op_i(ctrl.alu_op),
        .op1_i   (ex_i.op1),
        .op2_i   (ex_i.op2),
        .res_o   (alu_res)
    );

    branch_unit u_br (
        .br_cond_i    (ctrl.br_cond),
        .pc_i         (ex_i.pc),
        .op1_i        (ex_i.op1),
        .op2_i        (ex_i.op2),
        .jump_offset_i(ctrl.jump_offset),
        .alu_res_i    (alu_res),
        .jump_en_o    (jump_en),
        .jump_addr_o  (jump_addr)
    );

    load_align u_ld (
        .ld_kind_i  (ctrl.ld_kind),
        .byte_off_i (alu_res[1:0]), // low bits of rs1 + imm
        .ram_data_i (ram_rd_data_i),
        .load_data_o(load_data)
    );

    ////////////////////
    // write-back select

    assign link_addr = ex_i.pc + rv_pkg::INST_ADDR_STEP;
    assign pc_imm_u  = ex_i.pc + ctrl.imm_u;

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_ALU:      rd_data = alu_res;
            rv_pkg::WB_LOAD:     rd_data = load_data;
            rv_pkg::WB_IMM_U:    rd_data = ctrl.imm_u;
            rv_pkg::WB_PC_IMM_U: rd_data = pc_imm_u;
            rv_pkg::WB_PC_LINK:  rd_data = link_addr;
            rv_pkg::WB_NONE:     rd_data = '0;
            default:             rd_data = '0;
        endcase
    end

    always_comb begin
        ex_next.reg_wr_en = ctrl.reg_wr_en;
        ex_next.rd_addr   = ex_i.rd_addr;
        ex_next.rd_data   = rd_data;
        ex_next.jump_en   = jump_en;
        ex_next.jump_addr = jump_addr;
        if (!valid_i) begin
            ex_next = '0; // bubble
        end
    end

    ////////////////////
    // ex/mem register

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_o <= '0;
        end else begin
            ex_o <= ex_next;
        end
    end

endmodule

`default_nettype wire

/* test/tb_execute_stage.sv */
`default_nettype none

module tb_execute_stage;

    timeunit 1ns;
    timeprecision 1ps;

    logic            clk = 1'b0;
    logic            rst_i;
    logic            valid_i;
    rv_pkg::ex_in_t  ex_i;
    rv_pkg::word_t   ram_rd_data_i;
    rv_pkg::ex_out_t ex_o;

    int seed = 49;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    bit timed_out = 1'b0;

    rv_pkg::ex_in_t in_q[$]; // pending stream items
    rv_pkg::word_t  ram_q[$];
    logic           val_q[$];

    always #20 clk = ~clk; // 40 ns period

    execute_stage dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .ex_i         (ex_i),
        .ram_rd_data_i(ram_rd_data_i),
        .ex_o         (ex_o)
    );

    ////////////////////
    // instruction building

    function automatic rv_pkg::word_t enc(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, 10'h000, f3, 5'h00, opc};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [19:0] upper, input logic [6:0] opc);
        return {upper, 5'h00, opc};
    endfunction

    function automatic rv_pkg::ex_in_t make_in(input rv_pkg::word_t inst, input rv_pkg::word_t op1,
                                               input rv_pkg::word_t op2, input rv_pkg::word_t pc,
                                               input rv_pkg::word_t offset);
        rv_pkg::ex_in_t in;
        in.inst    = inst;
        in.pc      = pc;
        in.op1     = op1;
        in.op2     = op2;
        in.rd_addr = rv_pkg::reg_addr_t'($random(seed));
        in.offset  = offset;
        return in;
    endfunction

    ////////////////////
    // reference model

    function automatic rv_pkg::ex_out_t expect_out(input rv_pkg::ex_in_t in,
                                                   input rv_pkg::word_t ram, input logic valid);
        rv_pkg::ex_out_t o;
        logic [6:0]      opc;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic            alt;
        logic            ok;
        logic            take;
        rv_pkg::word_t   sum;
        rv_pkg::word_t   imm_u;
        rv_pkg::word_t   imm_j;
        logic [7:0]      b;
        logic [15:0]     h;
        opc   = in.inst[6:0];
        f3    = in.inst[14:12];
        f7    = in.inst[31:25];
        sum   = in.op1 + in.op2;
        imm_u = {in.inst[31:12], 12'h000};
        imm_j = {{12{in.inst[31]}}, in.inst[19:12], in.inst[20], in.inst[30:21], 1'b0};
        b     = 8'(ram >> (8 * sum[1:0]));
        h     = sum[1] ? ram[31:16] : ram[15:0];
        o     = '0;
        o.rd_addr = in.rd_addr;
        case (opc)
            rv_pkg::OPC_R, rv_pkg::OPC_I_ALU: begin
                alt = (f7 == 7'h20);
                ok  = (f7 == 7'h00) || (alt && (f3 == 3'd5 || (f3 == 3'd0 && opc == rv_pkg::OPC_R)));
                if (opc == rv_pkg::OPC_I_ALU && f3 != 3'd1 && f3 != 3'd5) ok = 1'b1;
                alt = alt && (f3 == 3'd5 || opc == rv_pkg::OPC_R); // sub only in r form
                o.reg_wr_en = ok;
                if (ok) begin
                    case (f3)
                        3'd0: o.rd_data = alt ? in.op1 - in.op2 : in.op1 + in.op2;
                        3'd1: o.rd_data = in.op1 << in.op2[4:0];
                        3'd2: o.rd_data = ($signed(in.op1) < $signed(in.op2)) ? 1 : 0;
                        3'd3: o.rd_data = (in.op1 < in.op2) ? 1 : 0;
                        3'd4: o.rd_data = in.op1 ^ in.op2;
                        3'd5: begin
                            if (alt) o.rd_data = $signed(in.op1) >>> in.op2[4:0];
                            else     o.rd_data = in.op1 >> in.op2[4:0];
                        end
                        3'd6: o.rd_data = in.op1 | in.op2;
                        default: o.rd_data = in.op1 & in.op2;
                    endcase
                end
            end
            rv_pkg::OPC_LOAD: begin
                o.reg_wr_en = 1'b1;
                case (f3)
                    3'd0: o.rd_data = {{24{b[7]}}, b};
                    3'd1: o.rd_data = {{16{h[15]}}, h};
                    3'd2: o.rd_data = ram;
                    3'd4: o.rd_data = {24'h0, b};
                    3'd5: o.rd_data = {16'h0, h};
                    default: o.reg_wr_en = 1'b0;
                endcase
            end
            rv_pkg::OPC_BRANCH: begin
                case (f3)
                    3'd0: take = (in.op1 == in.op2);
                    3'd1: take = (in.op1 != in.op2);
                    3'd4: take = ($signed(in.op1) < $signed(in.op2));
                    3'd5: take = ($signed(in.op1) >= $signed(in.op2));
                    3'd6: take = (in.op1 < in.op2);
                    3'd7: take = (in.op1 >= in.op2);
                    default: take = 1'b0;
                endcase
                o.jump_en   = take;
                o.jump_addr = take ? in.pc + in.offset : 32'h0;
            end
            rv_pkg::OPC_LUI: {o.reg_wr_en, o.rd_data} = {1'b1, imm_u};
            rv_pkg::OPC_AUIPC: {o.reg_wr_en, o.rd_data} = {1'b1, in.pc + imm_u};
            rv_pkg::OPC_JAL: begin
                {o.reg_wr_en, o.rd_data} = {1'b1, in.pc + 32'd4};
                {o.jump_en, o.jump_addr} = {1'b1, in.pc + imm_j};
            end
            rv_pkg::OPC_JALR: begin
                if (f3 == 3'd0) begin
                    {o.reg_wr_en, o.rd_data} = {1'b1, in.pc + 32'd4};
                    {o.jump_en, o.jump_addr} = {1'b1, sum & ~32'h1};
                end
            end
            default: ;
        endcase
        if (!valid) o = '0; // bubble
        return o;
    endfunction

    ////////////////////
    // compare and run

    task automatic check_word(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_out(input string name, input rv_pkg::ex_out_t exp,
                             input rv_pkg::ex_out_t act);
        if (act.reg_wr_en !== exp.reg_wr_en || act.jump_en !== exp.jump_en ||
            act.rd_addr !== exp.rd_addr) begin
            $display("[ERROR] %s: expected wr=%b rd=%0d jump=%b, actual wr=%b rd=%0d jump=%b",
                     name, exp.reg_wr_en, exp.rd_addr, exp.jump_en,
                     act.reg_wr_en, act.rd_addr, act.jump_en);
            err_count++;
        end
        check_word({name, " rd_data"}, exp.rd_data, act.rd_data);
        check_word({name, " jump_addr"}, exp.jump_addr, act.jump_addr);
    endtask

    task automatic push_item(input rv_pkg::ex_in_t in, input rv_pkg::word_t ram, input logic valid);
        in_q.push_back(in);
        ram_q.push_back(ram);
        val_q.push_back(valid);
    endtask

    // each result checked at the falling edge after its sample edge
    task automatic run_queue(input string name, input int start_errs);
        int n;
        n = in_q.size();
        for (int k = 0; k <= n; k++) begin
            @(posedge clk);
            if (k < n) begin
                ex_i          <= in_q[k];
                ram_rd_data_i <= ram_q[k];
                valid_i       <= val_q[k];
            end else begin
                valid_i <= 1'b0;
            end
            if (k > 0) begin
                @(negedge clk);
                check_out($sformatf("%s[%0d]", name, k - 1),
                          expect_out(in_q[k-1], ram_q[k-1], val_q[k-1]), ex_o);
            end
        end
        tests_run++;
        if (err_count != start_errs) tests_failed++;
        $display("%s: %0d items, %s", name, n, (err_count == start_errs) ? "ok" : "FAILED");
        in_q.delete();
        ram_q.delete();
        val_q.delete();
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_i !== 1'b0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (rst_i !== 1'b0) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    ////////////////////
    // tests

    task automatic reset_and_bubbles();
        int start;
        start = err_count;
        check_out("reset", '0, ex_o);
        push_item(make_in(enc(7'h00, 3'd0, rv_pkg::OPC_R), 32'h5, 32'h7, 32'h100, 0), 0, 1'b0);
        push_item(make_in(enc_u(20'h12345, rv_pkg::OPC_JAL), 0, 0, 32'h200, 0), 0, 1'b0);
        run_queue("reset_and_bubbles", start);
    endtask

    task automatic alu_ops();
        int            start;
        logic [6:0]    opc;
        rv_pkg::word_t inst;
        start = err_count;
        for (int i = 0; i < 2; i++) begin
            opc = (i == 0) ? rv_pkg::OPC_R : rv_pkg::OPC_I_ALU;
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 1 && !(f3 == 5 || (f3 == 0 && i == 0))) continue;
                    inst = enc(alt ? rv_pkg::FUNCT7_ALT : 7'h00, 3'(f3), opc);
                    repeat (2) push_item(make_in(inst, $random(seed), $random(seed), 0, 0), 0, 1);
                    if (f3 == 2 || f3 == 3) begin // sign boundary
                        push_item(make_in(inst, 32'h8000_0000, 32'h7fff_ffff, 0, 0), 0, 1);
                        push_item(make_in(inst, 32'h7fff_ffff, 32'h8000_0000, 0, 0), 0, 1);
                    end
                end
            end
        end
        run_queue("alu_ops", start);
    endtask

    task automatic load_lanes();
        int            start;
        rv_pkg::word_t base;
        start = err_count;
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 == 3) continue;
            for (int off = 0; off < 4; off++) begin
                base = $random(seed) & 32'hffff_fffc;
                push_item(make_in(enc(7'h00, 3'(f3), rv_pkg::OPC_LOAD), base, off, 0, 0),
                          32'h80f1_7f8e, 1'b1); // lanes of mixed sign
            end
        end
        run_queue("load_lanes", start);
    endtask

    task automatic cond_branches();
        int            start;
        logic [2:0]    f3s[6];
        rv_pkg::word_t a[3];
        rv_pkg::word_t b[3];
        start = err_count;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        a   = '{32'd5, -32'sd3, 32'd7}; // equal, less, greater
        b   = '{32'd5, 32'd7, -32'sd3};
        foreach (f3s[i]) begin
            for (int p = 0; p < 3; p++) begin
                push_item(make_in(enc(7'h00, f3s[i], rv_pkg::OPC_BRANCH), a[p], b[p],
                                  $random(seed) & 32'hffff_fffc, $random(seed) & 32'hffff_fffe),
                          0, 1'b1);
            end
        end
        run_queue("cond_branches", start);
    endtask

    task automatic jumps_and_upper();
        int start;
        start = err_count;
        push_item(make_in(enc_u(20'($random(seed)), rv_pkg::OPC_JAL), 0, 0, 32'h0000_4000, 0),
                  0, 1);
        push_item(make_in(enc(7'h01, 3'd0, rv_pkg::OPC_JALR), 32'h1000_0001, 32'h10,
                          32'h0000_8000, 0), 0, 1'b1); // odd sum
        push_item(make_in(enc_u(20'($random(seed)), rv_pkg::OPC_LUI), 0, 0, 32'h40, 0),
                  0, 1'b1);
        push_item(make_in(enc_u(20'($random(seed)), rv_pkg::OPC_AUIPC), 0, 0, 32'h1234_5678, 0),
                  0, 1'b1);
        run_queue("jumps_and_upper", start);
    endtask

    task automatic invalid_and_stream();
        int start;
        start = err_count;
        push_item(make_in(enc(7'h00, 3'd2, rv_pkg::OPC_STORE), 32'h10, 32'h4, 0, 0), 0, 1'b1);
        push_item(make_in(enc(7'h01, 3'd0, rv_pkg::OPC_R), 32'h10, 32'h4, 0, 0), 0, 1'b1);
        push_item(make_in(enc(7'h00, 3'd0, 7'h7f), 32'h10, 32'h4, 0, 0), 0, 1'b1);
        push_item(make_in(enc(7'h00, 3'd0, 7'h73), 0, 0, 0, 0), 0, 1'b1); // system
        push_item(make_in(enc(7'h00, 3'd0, rv_pkg::OPC_R), $random(seed), $random(seed), 0, 0),
                  0, 1'b1);
        push_item(make_in(enc(7'h00, 3'd2, rv_pkg::OPC_LOAD), 32'h20, 32'h0, 0, 0),
                  32'hdead_beef, 1'b1);
        push_item(make_in(enc(7'h00, 3'd0, rv_pkg::OPC_BRANCH), 32'h9, 32'h9, 32'h300, 32'h40),
                  0, 1'b1);
        push_item(make_in(enc_u(20'h80001, rv_pkg::OPC_JAL), 0, 0, 32'h340, 0), 0, 1'b1);
        push_item(make_in(enc_u(20'habcde, rv_pkg::OPC_LUI), 0, 0, 0, 0), 0, 1'b0);
        push_item(make_in(enc_u(20'h00001, rv_pkg::OPC_AUIPC), 0, 0, 32'h500, 0), 0, 1'b1);
        run_queue("invalid_and_stream", start);
    endtask

    ////////////////////
    // main sequence

    initial begin
        rst_i         = 1'b1;
        valid_i       = 1'b0;
        ex_i          = '0;
        ram_rd_data_i = '0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        wait_reset_release();
        if (!timed_out) begin
            reset_and_bubbles();
            alu_ops();
            load_lanes();
            cond_branches();
            jumps_and_upper();
            invalid_and_stream();
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (timed_out || err_count != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rtl/rv_pkg.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/load_align.sv
rtl/execute_stage.sv
test/tb_execute_stage.sv
